// ==== project.f ====
+incdir+tb
hw/vec_pkg.sv
hw/vec_decode_element.sv
hw/vec_alu.sv
hw/vec_regfile.sv
hw/vec_ctrl.sv
hw/vec_unit_top.sv
tb/vec_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the vector unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module vec_unit_tb -o vec_unit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/vec_unit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished"
exit 0

// ==== tb/vec_ref_model.svh ====
// ==============================
// Reference model for the vector
// unit, element-wise op results
// ==============================

`ifndef vec_ref_model_svh
`define vec_ref_model_svh

// New destination value after one instruction, tail bytes kept
function automatic vec_pkg::vec_data_t ref_execute(
    input vec_pkg::vec_op_e   op_sel,
    input vec_pkg::vec_data_t src_a,
    input vec_pkg::vec_data_t src_b,
    input vec_pkg::vec_data_t old_dest,
    input int                 sew_code,
    input int                 vl_elems
);
    vec_pkg::vec_data_t res;
    vec_pkg::vec_data_t mask;
    vec_pkg::vec_data_t ea;
    vec_pkg::vec_data_t eb;
    vec_pkg::vec_data_t er;
    int                 ebits;
    int                 nelem;

    res = old_dest;
    // Reserved element widths write nothing
    if (sew_code > 4) begin
        return res;
    end
    ebits = 8 << sew_code;
    nelem = 128 / ebits;
    if (ebits == 128) begin
        mask = '1;
    end else begin
        mask = (vec_pkg::vec_data_t'(1) << ebits) - vec_pkg::vec_data_t'(1);
    end
    for (int i = 0; i < nelem && i < vl_elems; i++) begin
        ea = (src_a >> (i * ebits)) & mask;
        eb = (src_b >> (i * ebits)) & mask;
        case (op_sel)
            vec_pkg::op_add: er = ea + eb;
            vec_pkg::op_sub: er = ea - eb;
            vec_pkg::op_and: er = ea & eb;
            default:         er = ea ^ eb;
        endcase
        // Wrap to the element width
        er = er & mask;
        res = (res & ~(mask << (i * ebits))) | (er << (i * ebits));
    end
    return res;
endfunction

`endif

// ==== tb/vec_unit_tb.sv ====
// ==============================
// Testbench for the vector unit,
// stimulus table, checks, watchdog
// ==============================

`default_nettype none

module vec_unit_tb;

    `include "vec_ref_model.svh"

    localparam int clk_period = 8;
    localparam int reset_cycles = 16;
    localparam int entry_cycles = 40;

    // One table row, expected values come from the reference model
    typedef struct packed {
        vec_pkg::vec_op_e   op;
        vec_pkg::reg_addr_t vs1;
        vec_pkg::reg_addr_t vs2;
        vec_pkg::reg_addr_t vd;
        vec_pkg::vec_vsew_t vsew;
        vec_pkg::vec_vl_t   vl;
        logic [1:0]         pat;
        logic               exp_illegal;
    } test_entry_t;

    logic                  clk;
    logic                  rst;
    logic                  start;
    vec_pkg::vec_op_e      op;
    vec_pkg::reg_addr_t    vs1;
    vec_pkg::reg_addr_t    vs2;
    vec_pkg::reg_addr_t    vd;
    vec_pkg::vec_vsew_t    vsew;
    vec_pkg::vec_vl_t      vl;
    logic                  load_en;
    vec_pkg::reg_addr_t    load_addr;
    vec_pkg::vec_data_t    load_data;
    vec_pkg::reg_addr_t    read_addr;
    logic                  busy;
    logic                  done;
    logic                  illegal;
    vec_pkg::vec_data_t    read_data;

    test_entry_t           test_table [$];
    vec_pkg::vec_data_t    model_regs [vec_pkg::num_regs];
    logic                  table_ready = 1'b0;

    vec_unit_top dut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .op        (op),
        .vs1       (vs1),
        .vs2       (vs2),
        .vd        (vd),
        .vsew      (vsew),
        .vl        (vl),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .read_addr (read_addr),
        .busy      (busy),
        .done      (done),
        .illegal   (illegal),
        .read_data (read_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input vec_pkg::vec_data_t got,
                               input vec_pkg::vec_data_t expected);
        if (got !== expected) begin
            $display("Error: %s got %h expected %h", name, got, expected);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic add_entry(input vec_pkg::vec_op_e op_sel, input int src1, input int src2,
                             input int dest, input int sew_code, input int vl_elems,
                             input int pattern, input logic ill);
        test_entry_t e;
        e.op = op_sel;
        e.vs1 = vec_pkg::reg_addr_t'(src1);
        e.vs2 = vec_pkg::reg_addr_t'(src2);
        e.vd = vec_pkg::reg_addr_t'(dest);
        e.vsew = vec_pkg::vec_vsew_t'(sew_code);
        e.vl = vec_pkg::vec_vl_t'(vl_elems);
        e.pat = 2'(pattern);
        e.exp_illegal = ill;
        test_table.push_back(e);
    endtask

    task automatic build_table();
        // Full vl at every width, random and per-byte overflow operands
        for (int s = 0; s < 5; s++) begin
            add_entry(vec_pkg::op_add, 0, 1, 2, s, 16 >> s, 0, 1'b0);
            add_entry(vec_pkg::op_sub, 1, 3, 0, s, 16 >> s, 0, 1'b0);
            add_entry(vec_pkg::op_add, 2, 3, 1, s, 16 >> s, 1, 1'b0);
            add_entry(vec_pkg::op_sub, 0, 2, 3, s, 16 >> s, 2, 1'b0);
        end
        add_entry(vec_pkg::op_and, 0, 1, 2, 0, 16, 0, 1'b0);
        add_entry(vec_pkg::op_xor, 3, 2, 1, 2, 4, 0, 1'b0);
        // Tail undisturbed, vl 0 leaves vd alone
        add_entry(vec_pkg::op_and, 1, 2, 3, 1, 5, 0, 1'b0);
        add_entry(vec_pkg::op_add, 2, 0, 3, 0, 7, 0, 1'b0);
        add_entry(vec_pkg::op_sub, 3, 1, 0, 2, 1, 0, 1'b0);
        add_entry(vec_pkg::op_xor, 0, 1, 2, 3, 0, 0, 1'b0);
        add_entry(vec_pkg::op_add, 0, 1, 2, 4, 0, 0, 1'b0);
        // Destination overlapping a source
        add_entry(vec_pkg::op_add, 1, 2, 1, 1, 8, 0, 1'b0);
        add_entry(vec_pkg::op_add, 2, 3, 3, 4, 1, 1, 1'b0);
        add_entry(vec_pkg::op_sub, 1, 1, 1, 0, 9, 0, 1'b0);
        // vl beyond the element count
        add_entry(vec_pkg::op_xor, 0, 1, 2, 2, 16, 0, 1'b0);
        // Reserved vsew codes
        add_entry(vec_pkg::op_add, 0, 1, 2, 5, 16, 0, 1'b1);
        add_entry(vec_pkg::op_sub, 1, 2, 3, 6, 4, 0, 1'b1);
        add_entry(vec_pkg::op_xor, 2, 3, 0, 7, 1, 0, 1'b1);
    endtask

    function automatic vec_pkg::vec_data_t random_vec();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic load_reg(input int r, input vec_pkg::vec_data_t val);
        @(negedge clk);
        load_en = 1'b1;
        load_addr = vec_pkg::reg_addr_t'(r);
        load_data = val;
        model_regs[r] = val;
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic check_regs();
        for (int r = 0; r < vec_pkg::num_regs; r++) begin
            @(negedge clk);
            read_addr = vec_pkg::reg_addr_t'(r);
            #1;
            check_value($sformatf("read_data[%0d]", r), read_data, model_regs[r]);
        end
    endtask

    task automatic run_entry(input test_entry_t e);
        vec_pkg::vec_data_t new_dest;
        int                 latency;
        for (int r = 0; r < vec_pkg::num_regs; r++) begin
            load_reg(r, random_vec());
        end
        // Operands that overflow or borrow in every byte
        if (e.pat == 2'd1) begin
            load_reg(int'(e.vs1), {16{8'hff}});
            load_reg(int'(e.vs2), {16{8'h01}});
        end else if (e.pat == 2'd2) begin
            load_reg(int'(e.vs1), '0);
            load_reg(int'(e.vs2), {16{8'h01}});
        end
        new_dest = ref_execute(e.op, model_regs[e.vs1], model_regs[e.vs2],
                               model_regs[e.vd], int'(e.vsew), int'(e.vl));
        latency = e.exp_illegal ? 2 : 3;
        @(negedge clk);
        start = 1'b1;
        op = e.op;
        vs1 = e.vs1;
        vs2 = e.vs2;
        vd = e.vd;
        vsew = e.vsew;
        vl = e.vl;
        // Cycles count from the edge that samples start
        for (int n = 1; n <= latency; n++) begin
            @(negedge clk);
            start = 1'b0;
            check_value("busy", 128'(busy), 128'(1'b1));
            check_value("done", 128'(done), 128'(n == latency));
        end
        check_value("illegal", 128'(illegal), 128'(e.exp_illegal));
        model_regs[e.vd] = new_dest;
        check_regs();
    endtask

    initial begin
        void'($urandom(83542));
        rst = 1'b1;
        start = 1'b0;
        op = vec_pkg::op_add;
        vs1 = '0;
        vs2 = '0;
        vd = '0;
        vsew = '0;
        vl = '0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        read_addr = '0;
        for (int r = 0; r < vec_pkg::num_regs; r++) begin
            model_regs[r] = '0;
        end
        build_table();
        table_ready = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("busy", 128'(busy), 128'(1'b0));
        check_value("done", 128'(done), 128'(1'b0));
        check_regs();
        foreach (test_table[t]) begin
            run_entry(test_table[t]);
        end
        $display("Testbench passed");
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (table_ready);
        #((reset_cycles + 10 + test_table.size() * entry_cycles) * clk_period);
        $display("Run timed out before all table entries finished");
        $display("Testbench failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== hw/vec_unit_top.sv ====
// ==============================
// Vector unit top level
// ==============================

`default_nettype none

module vec_unit_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  vec_pkg::vec_op_e      op,
    input  vec_pkg::reg_addr_t    vs1,
    input  vec_pkg::reg_addr_t    vs2,
    input  vec_pkg::reg_addr_t    vd,
    input  vec_pkg::vec_vsew_t    vsew,
    input  vec_pkg::vec_vl_t      vl,
    input  logic                  load_en,
    input  vec_pkg::reg_addr_t    load_addr,
    input  vec_pkg::vec_data_t    load_data,
    input  vec_pkg::reg_addr_t    read_addr,
    output logic                  busy,
    output logic                  done,
    output logic                  illegal,
    output vec_pkg::vec_data_t    read_data
);

    // Captured instruction fields
    vec_pkg::vec_op_e        ex_op;
    vec_pkg::reg_addr_t      rs1_addr;
    vec_pkg::reg_addr_t      rs2_addr;
    vec_pkg::reg_addr_t      wr_addr;
    vec_pkg::vec_vsew_t      ex_vsew;
    vec_pkg::vec_vl_t        ex_vl;
    logic                    alu_capture;
    logic                    wr_en;

    vec_pkg::vec_data_t      rs1_data;
    vec_pkg::vec_data_t      rs2_data;
    vec_pkg::vec_data_t      alu_result;
    vec_pkg::vec_merge_t     merge;
    vec_pkg::vec_byte_mask_t valid_bytes;

    vec_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .op_in       (op),
        .vs1_in      (vs1),
        .vs2_in      (vs2),
        .vd_in       (vd),
        .vsew_in     (vsew),
        .vl_in       (vl),
        .op          (ex_op),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .wr_addr     (wr_addr),
        .vsew        (ex_vsew),
        .vl          (ex_vl),
        .alu_capture (alu_capture),
        .wr_en       (wr_en),
        .busy        (busy),
        .done        (done),
        .illegal     (illegal)
    );

    vec_regfile u_regfile (
        .clk       (clk),
        .rst       (rst),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .read_addr (read_addr),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_bytes  (valid_bytes),
        .wr_data   (alu_result),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .read_data (read_data)
    );

    // Size one-hot is only needed inside the decode element
    vec_decode_element u_decode (
        .vsew        (ex_vsew),
        .vl          (ex_vl),
        .size_onehot (),
        .merge       (merge),
        .valid_bytes (valid_bytes)
    );

    vec_alu u_alu (
        .clk     (clk),
        .rst     (rst),
        .capture (alu_capture),
        .op      (ex_op),
        .srca    (rs1_data),
        .srcb    (rs2_data),
        .merge   (merge),
        .result  (alu_result)
    );

endmodule

`default_nettype wire

// ==== hw/vec_ctrl.sv ====
// ==============================
// Vector unit control: instruction
// capture and execute/write FSM
// ==============================

`default_nettype none

module vec_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  vec_pkg::vec_op_e     op_in,
    input  vec_pkg::reg_addr_t   vs1_in,
    input  vec_pkg::reg_addr_t   vs2_in,
    input  vec_pkg::reg_addr_t   vd_in,
    input  vec_pkg::vec_vsew_t   vsew_in,
    input  vec_pkg::vec_vl_t     vl_in,
    output vec_pkg::vec_op_e     op,
    output vec_pkg::reg_addr_t   rs1_addr,
    output vec_pkg::reg_addr_t   rs2_addr,
    output vec_pkg::reg_addr_t   wr_addr,
    output vec_pkg::vec_vsew_t   vsew,
    output vec_pkg::vec_vl_t     vl,
    output logic                 alu_capture,
    output logic                 wr_en,
    output logic                 busy,
    output logic                 done,
    output logic                 illegal
);

    vec_pkg::ctrl_state_e state;
    vec_pkg::ctrl_state_e state_next;
    logic                 accept;
    logic                 illegal_q;

    // Start only counts in idle, otherwise dropped
    assign accept = start && (state == vec_pkg::st_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= vec_pkg::st_idle;
            illegal_q <= 1'b0;
        end else begin
            state <= state_next;
            if (accept) begin
                illegal_q <= (vsew_in >= vec_pkg::vec_vsew_t'(vec_pkg::num_osizes));
            end
        end
    end

    // Instruction fields
    always_ff @(posedge clk) begin
        if (accept) begin
            op <= op_in;
            rs1_addr <= vs1_in;
            rs2_addr <= vs2_in;
            wr_addr <= vd_in;
            vsew <= vsew_in;
            vl <= vl_in;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            vec_pkg::st_idle:  if (accept) state_next = vec_pkg::st_exec;
            // Reserved vsew goes straight to done, nothing written
            vec_pkg::st_exec:  state_next = illegal_q ? vec_pkg::st_done : vec_pkg::st_write;
            vec_pkg::st_write: state_next = vec_pkg::st_done;
            vec_pkg::st_done:  state_next = vec_pkg::st_idle;
        endcase
    end

    assign alu_capture = (state == vec_pkg::st_exec);
    assign wr_en = (state == vec_pkg::st_write);
    assign busy = (state != vec_pkg::st_idle);
    assign done = (state == vec_pkg::st_done);
    assign illegal = done && illegal_q;

    a_done_pulse: assert property (
        @(posedge clk) disable iff (rst)
        done |=> !done
    ) else $error("done held longer than one cycle");

endmodule

`default_nettype wire

// ==== hw/vec_regfile.sv ====
// ==============================
// Vector register file, four regs,
// byte-enabled and load write ports
// ==============================

`default_nettype none

module vec_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  vec_pkg::reg_addr_t      rs1_addr,
    input  vec_pkg::reg_addr_t      rs2_addr,
    input  vec_pkg::reg_addr_t      read_addr,
    input  logic                    wr_en,
    input  vec_pkg::reg_addr_t      wr_addr,
    input  vec_pkg::vec_byte_mask_t wr_bytes,
    input  vec_pkg::vec_data_t      wr_data,
    input  logic                    load_en,
    input  vec_pkg::reg_addr_t      load_addr,
    input  vec_pkg::vec_data_t      load_data,
    output vec_pkg::vec_data_t      rs1_data,
    output vec_pkg::vec_data_t      rs2_data,
    output vec_pkg::vec_data_t      read_data
);

    vec_pkg::vec_data_t regs [vec_pkg::num_regs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < vec_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (load_en) begin
            regs[load_addr] <= load_data;
        end else if (wr_en) begin
            // Tail and inactive bytes keep their old value
            for (int b = 0; b < vec_pkg::vlen_bytes; b++) begin
                if (wr_bytes[b]) begin
                    regs[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // Combinational reads
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];
    assign read_data = regs[read_addr];

    // Loads come from outside, execute writes from the FSM
    a_write_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(load_en && wr_en)
    ) else $error("Load collided with execute write");

endmodule

`default_nettype wire

// ==== hw/vec_alu.sv ====
// ==============================
// Byte-lane vector ALU with merged
// carry chains, registered result
// ==============================

`default_nettype none

module vec_alu (
    input  logic                clk,
    input  logic                rst,
    input  logic                capture,
    input  vec_pkg::vec_op_e    op,
    input  vec_pkg::vec_data_t  srca,
    input  vec_pkg::vec_data_t  srcb,
    input  vec_pkg::vec_merge_t merge,
    output vec_pkg::vec_data_t  result
);

    logic                         is_sub;
    vec_pkg::vec_data_t           operand_b;
    vec_pkg::vec_data_t           sum;
    vec_pkg::vec_data_t           alu_out;
    logic [vec_pkg::vlen_bytes-1:0] carry_in;
    logic [vec_pkg::vlen_bytes-1:0] carry_out;

    // Subtract as a + ~b + 1, the +1 entering at each element start
    assign is_sub = (op == vec_pkg::op_sub);
    assign operand_b = is_sub ? ~srcb : srcb;

    assign carry_in[0] = is_sub;

    for (genvar b = 1; b < vec_pkg::vlen_bytes; b++) begin : gen_carry
        // Carry crosses the lane boundary only inside one element
        assign carry_in[b] = merge[b-1] ? carry_out[b-1] : is_sub;
    end

    for (genvar b = 0; b < vec_pkg::vlen_bytes; b++) begin : gen_adder
        assign {carry_out[b], sum[8*b +: 8]} = {1'b0, srca[8*b +: 8]} +
                                               {1'b0, operand_b[8*b +: 8]} +
                                               9'(carry_in[b]);
    end

    always_comb begin
        unique case (op)
            vec_pkg::op_add: alu_out = sum;
            vec_pkg::op_sub: alu_out = sum;
            vec_pkg::op_and: alu_out = srca & srcb;
            vec_pkg::op_xor: alu_out = srca ^ srcb;
        endcase
    end

    // Result holds until the next execute cycle
    always_ff @(posedge clk) begin
        if (capture) begin
            result <= alu_out;
        end
    end

    // One capture per instruction, the FSM never stays in execute
    a_capture_single: assert property (
        @(posedge clk) disable iff (rst)
        capture |=> !capture
    ) else $error("ALU capture held for two cycles");

endmodule

`default_nettype wire

// ==== hw/vec_decode_element.sv ====
// ==============================
// Per-element decode of vsew and vl
// into size one-hot, byte-merge mask
// and byte-valid mask
// ==============================

`default_nettype none

module vec_decode_element (
    input  vec_pkg::vec_vsew_t      vsew,
    input  vec_pkg::vec_vl_t        vl,
    output vec_pkg::osize_onehot_t  size_onehot,
    output vec_pkg::vec_merge_t     merge,
    output vec_pkg::vec_byte_mask_t valid_bytes
);

    // Candidate masks, one per legal size, gated by its one-hot bit
    vec_pkg::vec_merge_t     merge_size [vec_pkg::num_osizes];
    vec_pkg::vec_byte_mask_t valid_size [vec_pkg::num_osizes];

    // Size one-hot, reserved codes match no entry
    for (genvar s = 0; s < vec_pkg::num_osizes; s++) begin : gen_onehot
        assign size_onehot[s] = (vsew == vec_pkg::vec_vsew_t'(s));
    end

    for (genvar s = 0; s < vec_pkg::num_osizes; s++) begin : gen_size
        for (genvar b = 0; b < vec_pkg::vlen_bytes; b++) begin : gen_byte
            // Byte b belongs to element (b >> s) for 2**s byte elements
            assign valid_size[s][b] = size_onehot[s] &&
                                      (vl > vec_pkg::vec_vl_t'(b >> s));

            // Chain into the next byte unless b ends an element
            if (b < vec_pkg::vlen_bytes - 1) begin : gen_merge
                assign merge_size[s][b] = size_onehot[s] &&
                                          (((b + 1) % (1 << s)) != 0);
            end
        end
    end

    // At most one size is active, so OR picks its masks
    always_comb begin
        merge = '0;
        valid_bytes = '0;
        for (int s = 0; s < vec_pkg::num_osizes; s++) begin
            merge = merge | merge_size[s];
            valid_bytes = valid_bytes | valid_size[s];
        end
    end

endmodule

`default_nettype wire

// ==== hw/vec_pkg.sv ====
// ==============================
// Vector unit package with sizes,
// vector typedefs, the ALU op enum
// and the control FSM state enum
// ==============================

`default_nettype none

package vec_pkg;

    // Register geometry
    localparam int vlen_bytes = 16;
    localparam int vlen_bits = vlen_bytes * 8;
    localparam int num_regs = 4;
    localparam int reg_addr_bits = $clog2(num_regs);

    // Element sizes 8, 16, 32, 64 and 128 bits
    localparam int num_osizes = 5;
    localparam int vsew_bits = 3;

    // vl counts elements, 0 up to a full register of bytes
    localparam int vl_bits = $clog2(vlen_bytes + 1);

    // One full vector register
    typedef logic [vlen_bits-1:0] vec_data_t;

    // One bit per byte lane, for valid bytes and write enables
    typedef logic [vlen_bytes-1:0] vec_byte_mask_t;

    // Bit b set when bytes b and b+1 sit in the same element
    typedef logic [vlen_bytes-2:0] vec_merge_t;

    typedef logic [vl_bits-1:0] vec_vl_t;

    // Element width is (8 << vsew) bits, codes 5..7 reserved
    typedef logic [vsew_bits-1:0] vec_vsew_t;

    // Legal element size as a one-hot, all zero when reserved
    typedef logic [num_osizes-1:0] osize_onehot_t;

    typedef logic [reg_addr_bits-1:0] reg_addr_t;

    typedef enum logic [1:0] {
        op_add,
        op_sub,
        op_and,
        op_xor
    } vec_op_e;

    // Illegal instructions skip st_write
    typedef enum logic [1:0] {
        st_idle,
        st_exec,
        st_write,
        st_done
    } ctrl_state_e;

endpackage

`default_nettype wire
